// ==== sim.f ====
ex_isa_pkg.sv
ex_pipe_pkg.sv
int_alu.sv
branch_cond.sv
load_unit.sv
ex_stage.sv
ex_stage_checker.sv
ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - ex_isa_pkg.sv
      - ex_pipe_pkg.sv
      - int_alu.sv
      - branch_cond.sv
      - load_unit.sv
      - ex_stage.sv
  - target: simulation
    files:
      - ex_stage_checker.sv
      - ex_stage_tb.sv

// ==== ex_stage_tb.sv ====
`timescale 1ns/1ns

module ex_stage_tb import ex_isa_pkg::*, ex_pipe_pkg::*; ();

    localparam int item_count = 400;
    // a load with the longest cache delay plus the idle cycle
    localparam int item_cycles = 8;
    localparam int clock_period = 20;
    localparam xlen_t fill_offset = 32'h1357_9bdf;

    logic clock = 1'b0;
    logic reset;
    xlen_t opa, opb, rs1, rs2;
    alu_func_t alu_func;
    ex_packet_t packet;
    logic alu_en, branch_en, store_en, load_start;
    dword_t dcache_data;
    logic dcache_valid;
    xlen_t alu_result, branch_target, store_addr, load_addr, load_result;
    logic alu_done, branch_take, branch_done, store_done, load_req, load_done;
    mem_size_t store_size;
    ex_packet_t load_packet;
    int check_count;
    int error_count;
    logic [31:0] lfsr_state = 32'd63;

    always #(clock_period / 2) clock = ~clock;

    ex_stage DUT (.*);

    ex_stage_checker scoreboard (.*, .fill_offset(fill_offset));

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
    endfunction

    // one lfsr step per bit drawn
    function automatic logic [31:0] draw_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // one random alu, branch, store or load item
    task automatic run_item();
        logic [1:0] kind;
        ex_packet_t pkt;
        xlen_t first;
        int delay;
        kind = draw_bits(2);
        pkt.valid = 1'b1;
        pkt.rd_mem = kind == 2'd3;
        pkt.wr_mem = kind == 2'd2;
        pkt.dest = draw_bits(5);
        pkt.funct3 = draw_bits(3);
        first = draw_bits(32);
        @(posedge clock);
        opa <= draw_bits(32);
        opb <= draw_bits(32);
        rs1 <= first;
        // equal compare values about half the time
        rs2 <= draw_bits(1) ? first : draw_bits(32);
        // codes past sra exercise the default result
        alu_func <= (kind == 2'd3) ? alu_add : alu_func_t'(draw_bits(4));
        packet <= pkt;
        alu_en <= kind == 2'd0;
        branch_en <= kind == 2'd1;
        store_en <= kind == 2'd2;
        load_start <= kind == 2'd3;
        @(posedge clock);
        alu_en <= 1'b0;
        branch_en <= 1'b0;
        store_en <= 1'b0;
        load_start <= 1'b0;
        if (kind == 2'd3) begin
            // request is due one cycle after the start
            @(posedge clock);
            if (load_req) begin
                delay = draw_bits(2);
                repeat (delay) @(posedge clock);
                // cache line is a fixed function of its address
                dcache_data <= {~load_addr, load_addr + fill_offset};
                dcache_valid <= 1'b1;
                @(posedge clock);
                dcache_valid <= 1'b0;
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        opa = '0;
        opb = '0;
        rs1 = '0;
        rs2 = '0;
        alu_func = alu_add;
        packet = ex_packet_empty;
        alu_en = 1'b0;
        branch_en = 1'b0;
        store_en = 1'b0;
        load_start = 1'b0;
        dcache_data = '0;
        dcache_valid = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < item_count; i++) begin
            run_item();
        end
        // let the checker sample the last cycles
        repeat (2) @(posedge clock);
        @(negedge clock);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((16 + item_count * item_cycles + 20) * clock_period);
        $display("timeout: the run did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== ex_stage_checker.sv ====
`timescale 1ns/1ns

module ex_stage_checker import ex_isa_pkg::*, ex_pipe_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    // stimulus side of the DUT
    input  xlen_t      opa, opb, rs1, rs2,
    input  alu_func_t  alu_func,
    input  ex_packet_t packet,
    input  logic       alu_en, branch_en, store_en, load_start, dcache_valid,
    // response side of the DUT
    input  xlen_t      alu_result, branch_target, store_addr, load_addr, load_result,
    input  logic       alu_done, branch_take, branch_done, store_done, load_req, load_done,
    input  mem_size_t  store_size,
    input  ex_packet_t load_packet,
    // low word of a cache line is its address plus this
    input  xlen_t      fill_offset,
    output int         check_count,
    output int         error_count
);

    int checks = 0;
    int errors = 0;
    // load in flight as issued
    logic pending = 1'b0;
    // set once a reset edge has cleared the load unit
    logic reset_applied = 1'b0;
    xlen_t exp_addr;
    ex_packet_t exp_packet;
    int wait_cycles;

    assign check_count = checks;
    assign error_count = errors;

    task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic xlen_t ref_alu(xlen_t a, xlen_t b, alu_func_t f);
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_slt:  return {31'b0, $signed(a) < $signed(b)};
            alu_sltu: return {31'b0, a < b};
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            // shifts by the low five bits only
            alu_srl:  return a >> b[4:0];
            alu_sll:  return a << b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            default:  return 32'hfacebeec;
        endcase
    endfunction

    function automatic logic ref_branch(funct3_t f3, xlen_t a, xlen_t b);
        case (f3)
            funct3_beq:  return a == b;
            funct3_bne:  return a != b;
            funct3_blt:  return $signed(a) < $signed(b);
            funct3_bge:  return $signed(a) >= $signed(b);
            funct3_bltu: return a < b;
            funct3_bgeu: return a >= b;
            default:     return 1'b0;
        endcase
    endfunction

    // rebuild the cache line, pick the word, then extend
    function automatic xlen_t ref_load(funct3_t f3, xlen_t addr, xlen_t offset);
        logic [63:0] line;
        xlen_t word;
        line = {~addr, addr + offset};
        word = addr[2] ? line[63:32] : line[31:0];
        case (f3[1:0])
            2'b00:   return f3[2] ? {24'b0, word[7:0]} : {{24{word[7]}}, word[7:0]};
            2'b01:   return f3[2] ? {16'b0, word[15:0]} : {{16{word[15]}}, word[15:0]};
            default: return word;
        endcase
    endfunction

    always @(posedge clock) begin
        // done strobes mirror their enables
        compare("alu_done", alu_en, alu_done);
        compare("branch_done", branch_en, branch_done);
        compare("store_done", store_en, store_done);
        if (reset) begin
            pending = 1'b0;
        end
        if (!pending) begin
            // idle load unit, known only after the first reset edge
            if (reset_applied) begin
                compare("load_req", 0, load_req);
                compare("load_done", 0, load_done);
                compare("load_packet.valid", 0, load_packet.valid);
            end
        end else begin
            compare("load_req", exp_packet.valid & exp_packet.rd_mem, load_req);
            compare("load_addr", exp_addr, load_addr);
            compare("load_packet", exp_packet, load_packet);
            if (dcache_valid) begin
                if (load_done !== 1'b1) begin
                    errors++;
                    $display("Error at %0t: load_done missing although the cache answered",
                             $time);
                end
                compare("load_result", ref_load(exp_packet.funct3, exp_addr, fill_offset),
                        load_result);
                pending = 1'b0;
            end else begin
                compare("load_done", 0, load_done);
                wait_cycles++;
                // cache model answers within four cycles
                if (wait_cycles > 6) begin
                    errors++;
                    $display("Error at %0t: load_done never came for the pending load", $time);
                    pending = 1'b0;
                end
            end
        end
        if (reset) begin
            reset_applied = 1'b1;
        end
        if (!reset && load_start) begin
            pending = 1'b1;
            wait_cycles = 0;
            exp_addr = ref_alu(opa, opb, alu_func);
            exp_packet = packet;
        end
        if (!reset && alu_en) begin
            compare("alu_result", ref_alu(opa, opb, alu_func), alu_result);
        end
        if (!reset && branch_en) begin
            compare("branch_take", ref_branch(packet.funct3, rs1, rs2), branch_take);
            compare("branch_target", ref_alu(opa, opb, alu_func), branch_target);
        end
        if (!reset && store_en) begin
            compare("store_addr", opa + opb, store_addr);
            compare("store_size", packet.funct3[1:0], store_size);
        end
    end

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage import ex_isa_pkg::*, ex_pipe_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    // operands
    input  xlen_t      opa,
    input  xlen_t      opb,
    // branch compare values
    input  xlen_t      rs1,
    input  xlen_t      rs2,
    input  alu_func_t  alu_func,
    input  ex_packet_t packet,
    // one-cycle enables, one per path
    input  logic       alu_en,
    input  logic       branch_en,
    input  logic       store_en,
    input  logic       load_start,
    // data cache response
    input  dword_t     dcache_data,
    input  logic       dcache_valid,
    // alu path
    output xlen_t      alu_result,
    output logic       alu_done,
    // branch path
    output xlen_t      branch_target,
    output logic       branch_take,
    output logic       branch_done,
    // store path
    output xlen_t      store_addr,
    output mem_size_t  store_size,
    output logic       store_done,
    // load path
    output logic       load_req,
    output xlen_t      load_addr,
    output xlen_t      load_result,
    output ex_packet_t load_packet,
    output logic       load_done
);

    // combinational paths finish with their enable
    assign alu_done = alu_en;
    assign branch_done = branch_en;
    assign store_done = store_en;

    // plain integer op
    int_alu alu_path (
        .opa    (opa),
        .opb    (opb),
        .func   (alu_func),
        .result (alu_result)
    );

    // branch target, pc plus offset in the usual case
    int_alu branch_target_path (
        .opa    (opa),
        .opb    (opb),
        .func   (alu_func),
        .result (branch_target)
    );

    // taken or not from funct3 of the packet
    branch_cond branch_cond_path (
        .funct3 (packet.funct3),
        .rs1    (rs1),
        .rs2    (rs2),
        .take   (branch_take)
    );

    // store address is always base plus offset
    int_alu store_addr_path (
        .opa    (opa),
        .opb    (opb),
        .func   (alu_add),
        .result (store_addr)
    );

    assign store_size = mem_size_t'(packet.funct3[1:0]);

    // multi-cycle load through the data cache
    load_unit load_path (
        .clock        (clock),
        .reset        (reset),
        .start        (load_start),
        .opa          (opa),
        .opb          (opb),
        .func         (alu_func),
        .packet_in    (packet),
        .dcache_data  (dcache_data),
        .dcache_valid (dcache_valid),
        .req          (load_req),
        .addr         (load_addr),
        .result       (load_result),
        .packet_out   (load_packet),
        .done         (load_done)
    );

endmodule

// ==== load_unit.sv ====
`timescale 1ns/1ns

module load_unit import ex_isa_pkg::*, ex_pipe_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  xlen_t      opa,
    input  xlen_t      opb,
    input  alu_func_t  func,
    input  ex_packet_t packet_in,
    input  dword_t     dcache_data,
    input  logic       dcache_valid,
    output logic       req,
    output xlen_t      addr,
    output xlen_t      result,
    output ex_packet_t packet_out,
    output logic       done
);

    // load held while the cache answers
    logic busy;
    ex_packet_t held_packet;
    xlen_t held_opa;
    xlen_t held_opb;
    alu_func_t held_func;

    // response decode
    mem_size_t mem_size;
    logic zero_ext;
    xlen_t data_word;

    assign packet_out = held_packet;

    // request only for a real memory read
    assign req = busy && held_packet.valid && held_packet.rd_mem;

    // effective address from the held operands
    int_alu addr_alu (
        .opa    (held_opa),
        .opb    (held_opb),
        .func   (held_func),
        .result (addr)
    );

    // finishes in the cycle the cache answers
    assign done = busy && dcache_valid;

    assign mem_size = mem_size_t'(held_packet.funct3[1:0]);
    assign zero_ext = held_packet.funct3[2];
    // word pick from the double word
    assign data_word = addr[word_sel_bit] ? dcache_data[dword_width-1:xlen]
                                          : dcache_data[xlen-1:0];

    always_comb begin
        result = '0;
        if (done) begin
            case (mem_size)
                mem_byte: result = zero_ext ? {{(xlen-8){1'b0}}, data_word[7:0]}
                                            : {{(xlen-8){data_word[7]}}, data_word[7:0]};
                mem_half: result = zero_ext ? {{(xlen-16){1'b0}}, data_word[15:0]}
                                            : {{(xlen-16){data_word[15]}}, data_word[15:0]};
                // full words pass unchanged
                default:  result = data_word;
            endcase
        end
    end

    // control state, a new start wins over completion
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            held_packet <= ex_packet_empty;
        end else if (start) begin
            busy <= 1'b1;
            held_packet <= packet_in;
        end else if (done) begin
            busy <= 1'b0;
            held_packet <= ex_packet_empty;
        end
    end

    // operands only change on a new load
    always_ff @(posedge clock) begin
        if (start) begin
            held_opa <= opa;
            held_opb <= opb;
            held_func <= func;
        end
    end

endmodule

// ==== branch_cond.sv ====
`timescale 1ns/1ns

module branch_cond import ex_isa_pkg::*; (
    input  funct3_t funct3,
    input  xlen_t   rs1,
    input  xlen_t   rs2,
    output logic    take
);

    logic signed [xlen-1:0] signed_rs1;
    logic signed [xlen-1:0] signed_rs2;

    // blt and bge compare as signed
    assign signed_rs1 = rs1;
    assign signed_rs2 = rs2;

    always_comb begin
        case (funct3)
            funct3_beq:  take = rs1 == rs2;
            funct3_bne:  take = rs1 != rs2;
            funct3_blt:  take = signed_rs1 < signed_rs2;
            funct3_bge:  take = signed_rs1 >= signed_rs2;
            funct3_bltu: take = rs1 < rs2;
            funct3_bgeu: take = rs1 >= rs2;
            // codes 2 and 3 are not branches
            default:     take = 1'b0;
        endcase
    end

endmodule

// ==== int_alu.sv ====
`timescale 1ns/1ns

module int_alu import ex_isa_pkg::*; (
    input  xlen_t     opa,
    input  xlen_t     opb,
    input  alu_func_t func,
    output xlen_t     result
);

    logic signed [xlen-1:0] signed_opa;
    logic signed [xlen-1:0] signed_opb;
    shamt_t shamt;

    // signed views for slt and sra
    assign signed_opa = opa;
    assign signed_opb = opb;
    // shift amount from the low bits of opb
    assign shamt = opb[shamt_width-1:0];

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            // compare result lands in bit 0
            alu_slt:  result = {{(xlen-1){1'b0}}, signed_opa < signed_opb};
            alu_sltu: result = {{(xlen-1){1'b0}}, opa < opb};
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            alu_srl:  result = opa >> shamt;
            alu_sll:  result = opa << shamt;
            // arithmetic shift keeps the sign
            alu_sra:  result = xlen_t'(signed_opa >>> shamt);
            // recognizable pattern for unlisted codes
            default:  result = alu_default_result;
        endcase
    end

endmodule

// ==== ex_pipe_pkg.sv ====
package ex_pipe_pkg;

    import ex_isa_pkg::*;

    // one data cache access returns a double word
    localparam int dword_width = 2 * xlen;
    // address bit that selects the upper word of the double word
    localparam int word_sel_bit = 2;
    // architectural register file has 32 entries
    localparam int tag_width = 5;

    // data cache return word
    typedef logic [dword_width-1:0] dword_t;
    // destination register tag
    typedef logic [tag_width-1:0] tag_t;

    // issue packet, reduced to what the execute stage reads
    typedef struct packed {
        // slot holds a real instruction
        logic valid;
        // instruction reads memory
        logic rd_mem;
        // instruction writes memory
        logic wr_mem;
        // destination register
        tag_t dest;
        // funct3 of the instruction, branch condition or access size
        funct3_t funct3;
    } ex_packet_t;

    // an empty slot
    localparam ex_packet_t ex_packet_empty = '{
        valid: 1'b0,
        rd_mem: 1'b0,
        wr_mem: 1'b0,
        dest: '0,
        funct3: '0
    };

endpackage

// ==== ex_isa_pkg.sv ====
package ex_isa_pkg;

    // data path width of the core
    localparam int xlen = 32;
    // only the low bits of opb drive a shift
    localparam int shamt_width = 5;
    // result for a function code outside the ten below
    localparam logic [xlen-1:0] alu_default_result = 32'hfacebeec;

    // operands, results and addresses
    typedef logic [xlen-1:0] xlen_t;
    // shift amount
    typedef logic [shamt_width-1:0] shamt_t;
    // funct3 field of the instruction
    typedef logic [2:0] funct3_t;

    // integer alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_slt,
        alu_sltu,
        alu_or,
        alu_xor,
        alu_srl,
        alu_sll,
        alu_sra
    } alu_func_t;

    // conditional branch funct3 codes, 2 and 3 unused
    localparam funct3_t funct3_beq = 3'd0;
    localparam funct3_t funct3_bne = 3'd1;
    localparam funct3_t funct3_blt = 3'd4;
    localparam funct3_t funct3_bge = 3'd5;
    localparam funct3_t funct3_bltu = 3'd6;
    localparam funct3_t funct3_bgeu = 3'd7;

    // load funct3 codes, bit 2 set means zero extension
    localparam funct3_t funct3_lb = 3'd0;
    localparam funct3_t funct3_lh = 3'd1;
    localparam funct3_t funct3_lw = 3'd2;
    localparam funct3_t funct3_lbu = 3'd4;
    localparam funct3_t funct3_lhu = 3'd5;

    // access size, from funct3 bits 1..0
    typedef enum logic [1:0] {
        mem_byte = 2'b00,
        mem_half = 2'b01,
        mem_word = 2'b10
    } mem_size_t;

endpackage
